//--- include/rvv_shift_params.svh
`ifndef RVV_SHIFT_PARAMS_SVH
`define RVV_SHIFT_PARAMS_SVH

// vector register geometry
`define VLEN             64
`define VLENB            (`VLEN/8)

// element widths
`define BYTE_WIDTH       8
`define HWORD_WIDTH      16
`define WORD_WIDTH       32

// lanes per element width
`define LANES8           (`VLEN/`BYTE_WIDTH)
`define LANES16          (`VLEN/`HWORD_WIDTH)
`define LANES32          (`VLEN/`WORD_WIDTH)

// shift amount widths, log2 of the element width
`define SHAMT8_WIDTH     $clog2(`BYTE_WIDTH)
`define SHAMT16_WIDTH    $clog2(`HWORD_WIDTH)
`define SHAMT32_WIDTH    $clog2(`WORD_WIDTH)

// uop fields
`define ROB_DEPTH_WIDTH  3
`define XLEN             32
`define UOP_INDEX_WIDTH  3

`endif

//--- hw/rvv_shift_pkg.sv
`include "rvv_shift_params.svh"

package rvv_shift_pkg;

  // OPI shift encodings
  typedef enum logic [5:0] {
    VSLL    = 6'b100101,
    VSRL    = 6'b101000,
    VSRA    = 6'b101001,
    VSSRL   = 6'b101010,
    VSSRA   = 6'b101011,
    VNSRL   = 6'b101100,
    VNSRA   = 6'b101101,
    VNCLIPU = 6'b101110,
    VNCLIP  = 6'b101111
  } funct6_e;

  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPIVI = 3'b011,
    OPIVX = 3'b100
  } funct3_e;

  // fixed-point rounding mode
  typedef enum logic [1:0] {
    RNU = 2'd0,
    RNE = 2'd1,
    RDN = 2'd2,
    ROD = 2'd3
  } vxrm_e;

  typedef enum logic [1:0] {
    EEW8  = 2'd0,
    EEW16 = 2'd1,
    EEW32 = 2'd2
  } eew_e;

  typedef enum logic [1:0] {
    SHIFT_SLL = 2'd0,
    SHIFT_SRL = 2'd1,
    SHIFT_SRA = 2'd2
  } shift_op_e;

  typedef enum logic [1:0] {
    KIND_PLAIN  = 2'd0,
    KIND_SCALE  = 2'd1,
    KIND_NARROW = 2'd2,
    KIND_CLIP   = 2'd3
  } shift_kind_e;

  typedef logic [`BYTE_WIDTH-1:0]  elem8_t;
  typedef logic [`HWORD_WIDTH-1:0] elem16_t;
  typedef logic [`WORD_WIDTH-1:0]  elem32_t;

endpackage

//--- hw/rvv_shift_decode.sv
`timescale 1ns/100ps

module rvv_shift_decode (
  input  logic                        clk,
  input  rvv_shift_pkg::funct6_e      funct6,
  input  rvv_shift_pkg::funct3_e      funct3,
  input  rvv_shift_pkg::eew_e         vs2_eew,
  output rvv_shift_pkg::shift_op_e    shift_op,
  output rvv_shift_pkg::shift_kind_e  kind,
  output logic                        use_scalar,
  output logic                        legal
);

  logic known_op;
  logic known_form;
  logic wide_eew;
  logic narrowing;

  always_comb begin
    shift_op = rvv_shift_pkg::SHIFT_SLL;
    kind     = rvv_shift_pkg::KIND_PLAIN;
    known_op = 1'b1;
    case (funct6)
      rvv_shift_pkg::VSLL:    shift_op = rvv_shift_pkg::SHIFT_SLL;
      rvv_shift_pkg::VSRL:    shift_op = rvv_shift_pkg::SHIFT_SRL;
      rvv_shift_pkg::VSRA:    shift_op = rvv_shift_pkg::SHIFT_SRA;
      rvv_shift_pkg::VSSRL: begin
        shift_op = rvv_shift_pkg::SHIFT_SRL;
        kind     = rvv_shift_pkg::KIND_SCALE;
      end
      rvv_shift_pkg::VSSRA: begin
        shift_op = rvv_shift_pkg::SHIFT_SRA;
        kind     = rvv_shift_pkg::KIND_SCALE;
      end
      rvv_shift_pkg::VNSRL: begin
        shift_op = rvv_shift_pkg::SHIFT_SRL;
        kind     = rvv_shift_pkg::KIND_NARROW;
      end
      rvv_shift_pkg::VNSRA: begin
        shift_op = rvv_shift_pkg::SHIFT_SRA;
        kind     = rvv_shift_pkg::KIND_NARROW;
      end
      rvv_shift_pkg::VNCLIPU: begin
        shift_op = rvv_shift_pkg::SHIFT_SRL;
        kind     = rvv_shift_pkg::KIND_CLIP;
      end
      rvv_shift_pkg::VNCLIP: begin
        shift_op = rvv_shift_pkg::SHIFT_SRA;
        kind     = rvv_shift_pkg::KIND_CLIP;
      end
      default: known_op = 1'b0;
    endcase
  end

  // immediate form already sits in rs1_data
  assign use_scalar = (funct3 == rvv_shift_pkg::OPIVX) || (funct3 == rvv_shift_pkg::OPIVI);
  assign known_form = use_scalar || (funct3 == rvv_shift_pkg::OPIVV);
  assign wide_eew   = (vs2_eew == rvv_shift_pkg::EEW16) || (vs2_eew == rvv_shift_pkg::EEW32);
  // narrowing shifts and clips share the funct6 prefix 1011
  assign narrowing  = (funct6[5:2] == 4'b1011);

  always_comb begin
    if (narrowing) begin
      legal = known_op && known_form && wide_eew;
    end else begin
      legal = known_op && known_form && (wide_eew || (vs2_eew == rvv_shift_pkg::EEW8));
    end
  end

  // no source wider than a byte lane exists at EEW8
  assert property (@(posedge clk)
    (legal && ((kind == rvv_shift_pkg::KIND_NARROW) || (kind == rvv_shift_pkg::KIND_CLIP)))
      |-> (vs2_eew != rvv_shift_pkg::EEW8))
    else $error("narrowing uop decoded as legal at EEW8");

endmodule

//--- hw/rvv_shift_operand.sv
`timescale 1ns/100ps
`include "rvv_shift_params.svh"

module rvv_shift_operand (
  input  rvv_shift_pkg::eew_e                            vs2_eew,
  input  logic                                           use_scalar,
  input  rvv_shift_pkg::shift_kind_e                     kind,
  input  logic [`UOP_INDEX_WIDTH-1:0]                    uop_index,
  input  logic [`VLEN-1:0]                               vs1_data,
  input  logic [`VLEN-1:0]                               vs2_data,
  input  logic [`XLEN-1:0]                               rs1_data,
  output rvv_shift_pkg::elem8_t  [`LANES8-1:0]           operand8,
  output logic [`LANES8-1:0][`SHAMT8_WIDTH-1:0]          amount8,
  output rvv_shift_pkg::elem16_t [`LANES16-1:0]          operand16,
  output logic [`LANES16-1:0][`SHAMT16_WIDTH-1:0]        amount16,
  output rvv_shift_pkg::elem32_t [`LANES32-1:0]          operand32,
  output logic [`LANES32-1:0][`SHAMT32_WIDTH-1:0]        amount32
);

  logic               narrow;
  logic [`VLEN/2-1:0] vs1_half;

  assign narrow   = (kind == rvv_shift_pkg::KIND_NARROW) || (kind == rvv_shift_pkg::KIND_CLIP);
  // narrow-width amounts come from the half of vs1 this uop writes
  assign vs1_half = uop_index[0] ? vs1_data[`VLEN/2 +: `VLEN/2] : vs1_data[0 +: `VLEN/2];

  always_comb begin
    operand8  = '0;
    amount8   = '0;
    operand16 = '0;
    amount16  = '0;
    operand32 = '0;
    amount32  = '0;
    case (vs2_eew)
      rvv_shift_pkg::EEW8: begin
        for (int i = 0; i < `LANES8; i++) begin
          operand8[i] = vs2_data[i*`BYTE_WIDTH +: `BYTE_WIDTH];
          amount8[i]  = use_scalar ? rs1_data[`SHAMT8_WIDTH-1:0] :
                                     vs1_data[i*`BYTE_WIDTH +: `SHAMT8_WIDTH];
        end
      end
      rvv_shift_pkg::EEW16: begin
        for (int i = 0; i < `LANES16; i++) begin
          operand16[i] = vs2_data[i*`HWORD_WIDTH +: `HWORD_WIDTH];
          if (use_scalar) begin
            amount16[i] = rs1_data[`SHAMT16_WIDTH-1:0];
          end else if (narrow) begin
            amount16[i] = vs1_half[i*`BYTE_WIDTH +: `SHAMT16_WIDTH];
          end else begin
            amount16[i] = vs1_data[i*`HWORD_WIDTH +: `SHAMT16_WIDTH];
          end
        end
      end
      rvv_shift_pkg::EEW32: begin
        for (int i = 0; i < `LANES32; i++) begin
          operand32[i] = vs2_data[i*`WORD_WIDTH +: `WORD_WIDTH];
          if (use_scalar) begin
            amount32[i] = rs1_data[`SHAMT32_WIDTH-1:0];
          end else if (narrow) begin
            amount32[i] = vs1_half[i*`HWORD_WIDTH +: `SHAMT32_WIDTH];
          end else begin
            amount32[i] = vs1_data[i*`WORD_WIDTH +: `SHAMT32_WIDTH];
          end
        end
      end
      default: begin
        operand8 = '0;
      end
    endcase
  end

endmodule

//--- hw/rvv_shift_lane.sv
`timescale 1ns/100ps

module rvv_shift_lane #(
  parameter type elem_t = rvv_shift_pkg::elem8_t
) (
  input  rvv_shift_pkg::shift_op_e          shift_op,
  input  rvv_shift_pkg::vxrm_e              vxrm,
  input  elem_t                             operand,
  input  logic [$clog2($bits(elem_t))-1:0]  amount,
  output elem_t                             shifted,
  output elem_t                             rounded,
  output logic                              carry
);

  localparam int width = $bits(elem_t);

  // element sits above width zero bits, shifted-out bits land there
  logic signed [2*width:0] field;
  logic signed [2*width:0] moved;
  elem_t                   round_bits;
  logic                    increment;
  logic                    ext;

  always_comb begin
    if (shift_op == rvv_shift_pkg::SHIFT_SRA) begin
      field = {operand[width-1], operand, {width{1'b0}}};
    end else begin
      field = {1'b0, operand, {width{1'b0}}};
    end
    if (shift_op == rvv_shift_pkg::SHIFT_SLL) begin
      moved = field << amount;
    end else begin
      moved = field >>> amount;
    end
  end

  assign shifted    = moved[2*width-1:width];
  assign round_bits = moved[width-1:0];

  always_comb begin
    case (vxrm)
      rvv_shift_pkg::RNU: increment = round_bits[width-1];
      rvv_shift_pkg::RNE: increment = round_bits[width-1] &
                                      ((|round_bits[width-2:0]) | shifted[0]);
      rvv_shift_pkg::RDN: increment = 1'b0;
      default:            increment = ~shifted[0] & (|round_bits);
    endcase
  end

  // carry is the extra top bit, used by the clip range check
  assign ext              = (shift_op == rvv_shift_pkg::SHIFT_SRA) ? shifted[width-1] : 1'b0;
  assign {carry, rounded} = {ext, shifted} + (width+1)'(increment);

endmodule

//--- hw/rvv_shift_result.sv
`timescale 1ns/100ps
`include "rvv_shift_params.svh"

module rvv_shift_result (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    uop_valid,
  input  logic                                    legal,
  input  rvv_shift_pkg::shift_kind_e              kind,
  input  rvv_shift_pkg::shift_op_e                shift_op,
  input  rvv_shift_pkg::eew_e                     vs2_eew,
  input  logic [`UOP_INDEX_WIDTH-1:0]             uop_index,
  input  logic [`ROB_DEPTH_WIDTH-1:0]             rob_entry,
  input  rvv_shift_pkg::elem8_t  [`LANES8-1:0]    shifted8,
  input  rvv_shift_pkg::elem8_t  [`LANES8-1:0]    rounded8,
  input  rvv_shift_pkg::elem16_t [`LANES16-1:0]   shifted16,
  input  rvv_shift_pkg::elem16_t [`LANES16-1:0]   rounded16,
  input  logic [`LANES16-1:0]                     carry16,
  input  rvv_shift_pkg::elem32_t [`LANES32-1:0]   shifted32,
  input  rvv_shift_pkg::elem32_t [`LANES32-1:0]   rounded32,
  input  logic [`LANES32-1:0]                     carry32,
  output logic                                    result_valid,
  output logic [`ROB_DEPTH_WIDTH-1:0]             result_rob_entry,
  output logic [`VLEN-1:0]                        result_data,
  output logic                                    result_vxsat
);

  logic [`VLEN/2-1:0]   narrow16;
  logic [`VLEN/2-1:0]   narrow32;
  logic [`VLEN/2-1:0]   narrowed;
  logic [`LANES16-1:0]  sat16;
  logic [`LANES32-1:0]  sat32;
  logic [`VLEN-1:0]     data_next;
  logic                 vxsat_next;
  logic                 accept;

  // 16-bit lanes down to bytes
  always_comb begin
    narrow16 = '0;
    sat16    = '0;
    for (int i = 0; i < `LANES16; i++) begin
      if (kind != rvv_shift_pkg::KIND_CLIP) begin
        narrow16[i*`BYTE_WIDTH +: `BYTE_WIDTH] = shifted16[i][`BYTE_WIDTH-1:0];
      end else if (shift_op == rvv_shift_pkg::SHIFT_SRL) begin
        sat16[i] = |{carry16[i], rounded16[i][`HWORD_WIDTH-1:`BYTE_WIDTH]};
        narrow16[i*`BYTE_WIDTH +: `BYTE_WIDTH] =
          sat16[i] ? {`BYTE_WIDTH{1'b1}} : rounded16[i][`BYTE_WIDTH-1:0];
      end else begin
        sat16[i] = {carry16[i], rounded16[i][`HWORD_WIDTH-1:`BYTE_WIDTH]} !=
                   {(`BYTE_WIDTH+1){rounded16[i][`BYTE_WIDTH-1]}};
        // carry holds the true sign, so it picks min or max
        narrow16[i*`BYTE_WIDTH +: `BYTE_WIDTH] =
          sat16[i] ? {carry16[i], {(`BYTE_WIDTH-1){~carry16[i]}}} :
                     rounded16[i][`BYTE_WIDTH-1:0];
      end
    end
  end

  // 32-bit lanes down to half-words
  always_comb begin
    narrow32 = '0;
    sat32    = '0;
    for (int i = 0; i < `LANES32; i++) begin
      if (kind != rvv_shift_pkg::KIND_CLIP) begin
        narrow32[i*`HWORD_WIDTH +: `HWORD_WIDTH] = shifted32[i][`HWORD_WIDTH-1:0];
      end else if (shift_op == rvv_shift_pkg::SHIFT_SRL) begin
        sat32[i] = |{carry32[i], rounded32[i][`WORD_WIDTH-1:`HWORD_WIDTH]};
        narrow32[i*`HWORD_WIDTH +: `HWORD_WIDTH] =
          sat32[i] ? {`HWORD_WIDTH{1'b1}} : rounded32[i][`HWORD_WIDTH-1:0];
      end else begin
        sat32[i] = {carry32[i], rounded32[i][`WORD_WIDTH-1:`HWORD_WIDTH]} !=
                   {(`HWORD_WIDTH+1){rounded32[i][`HWORD_WIDTH-1]}};
        narrow32[i*`HWORD_WIDTH +: `HWORD_WIDTH] =
          sat32[i] ? {carry32[i], {(`HWORD_WIDTH-1){~carry32[i]}}} :
                     rounded32[i][`HWORD_WIDTH-1:0];
      end
    end
  end

  assign narrowed   = (vs2_eew == rvv_shift_pkg::EEW16) ? narrow16 : narrow32;
  assign vxsat_next = (kind == rvv_shift_pkg::KIND_CLIP) &&
                      ((vs2_eew == rvv_shift_pkg::EEW16) ? (|sat16) : (|sat32));
  assign accept     = uop_valid && legal;

  always_comb begin
    case (kind)
      rvv_shift_pkg::KIND_PLAIN: begin
        case (vs2_eew)
          rvv_shift_pkg::EEW8:  data_next = shifted8;
          rvv_shift_pkg::EEW16: data_next = shifted16;
          default:              data_next = shifted32;
        endcase
      end
      rvv_shift_pkg::KIND_SCALE: begin
        case (vs2_eew)
          rvv_shift_pkg::EEW8:  data_next = rounded8;
          rvv_shift_pkg::EEW16: data_next = rounded16;
          default:              data_next = rounded32;
        endcase
      end
      // narrow results fill one half, the other stays zero
      default: begin
        data_next = uop_index[0] ? {narrowed, {(`VLEN/2){1'b0}}} :
                                   {{(`VLEN/2){1'b0}}, narrowed};
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
      result_vxsat <= 1'b0;
      result_data  <= '0;
    end else begin
      result_valid <= accept;
      result_vxsat <= accept && vxsat_next;
      result_data  <= accept ? data_next : '0;
    end
  end

  always_ff @(posedge clk) begin
    result_rob_entry <= rob_entry;
  end

  // the narrowed mux only has 16-bit and 32-bit sources
  assert property (@(posedge clk) disable iff (reset)
    (accept && ((kind == rvv_shift_pkg::KIND_NARROW) || (kind == rvv_shift_pkg::KIND_CLIP)))
      |-> ((vs2_eew == rvv_shift_pkg::EEW16) || (vs2_eew == rvv_shift_pkg::EEW32)))
    else $error("narrowing uop accepted without a 16-bit or 32-bit source");

endmodule

//--- hw/rvv_alu_unit_shift.sv
`timescale 1ns/100ps
`include "rvv_shift_params.svh"

module rvv_alu_unit_shift (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          uop_valid,
  input  rvv_shift_pkg::funct6_e        funct6,
  input  rvv_shift_pkg::funct3_e        funct3,
  input  rvv_shift_pkg::vxrm_e          vxrm,
  input  rvv_shift_pkg::eew_e           vs2_eew,
  input  logic [`UOP_INDEX_WIDTH-1:0]   uop_index,
  input  logic [`ROB_DEPTH_WIDTH-1:0]   rob_entry,
  input  logic [`VLEN-1:0]              vs1_data,
  input  logic [`VLEN-1:0]              vs2_data,
  input  logic [`XLEN-1:0]              rs1_data,
  output logic                          result_valid,
  output logic [`ROB_DEPTH_WIDTH-1:0]   result_rob_entry,
  output logic [`VLEN-1:0]              result_data,
  output logic                          result_vxsat
);

  rvv_shift_pkg::shift_op_e                       shift_op;
  rvv_shift_pkg::shift_kind_e                     kind;
  logic                                           use_scalar;
  logic                                           legal;
  rvv_shift_pkg::elem8_t  [`LANES8-1:0]           operand8;
  rvv_shift_pkg::elem8_t  [`LANES8-1:0]           shifted8;
  rvv_shift_pkg::elem8_t  [`LANES8-1:0]           rounded8;
  logic [`LANES8-1:0][`SHAMT8_WIDTH-1:0]          amount8;
  rvv_shift_pkg::elem16_t [`LANES16-1:0]          operand16;
  rvv_shift_pkg::elem16_t [`LANES16-1:0]          shifted16;
  rvv_shift_pkg::elem16_t [`LANES16-1:0]          rounded16;
  logic [`LANES16-1:0][`SHAMT16_WIDTH-1:0]        amount16;
  logic [`LANES16-1:0]                            carry16;
  rvv_shift_pkg::elem32_t [`LANES32-1:0]          operand32;
  rvv_shift_pkg::elem32_t [`LANES32-1:0]          shifted32;
  rvv_shift_pkg::elem32_t [`LANES32-1:0]          rounded32;
  logic [`LANES32-1:0][`SHAMT32_WIDTH-1:0]        amount32;
  logic [`LANES32-1:0]                            carry32;

  rvv_shift_decode i_decode (
    .clk        (clk),
    .funct6     (funct6),
    .funct3     (funct3),
    .vs2_eew    (vs2_eew),
    .shift_op   (shift_op),
    .kind       (kind),
    .use_scalar (use_scalar),
    .legal      (legal)
  );

  rvv_shift_operand i_operand (
    .vs2_eew    (vs2_eew),
    .use_scalar (use_scalar),
    .kind       (kind),
    .uop_index  (uop_index),
    .vs1_data   (vs1_data),
    .vs2_data   (vs2_data),
    .rs1_data   (rs1_data),
    .operand8   (operand8),
    .amount8    (amount8),
    .operand16  (operand16),
    .amount16   (amount16),
    .operand32  (operand32),
    .amount32   (amount32)
  );

  // byte lanes never clip, their carry is not needed
  for (genvar i = 0; i < `LANES8; i++) begin : g_lane8
    rvv_shift_lane #(.elem_t(rvv_shift_pkg::elem8_t)) i_lane (
      .shift_op (shift_op),
      .vxrm     (vxrm),
      .operand  (operand8[i]),
      .amount   (amount8[i]),
      .shifted  (shifted8[i]),
      .rounded  (rounded8[i]),
      .carry    ()
    );
  end

  for (genvar i = 0; i < `LANES16; i++) begin : g_lane16
    rvv_shift_lane #(.elem_t(rvv_shift_pkg::elem16_t)) i_lane (
      .shift_op (shift_op),
      .vxrm     (vxrm),
      .operand  (operand16[i]),
      .amount   (amount16[i]),
      .shifted  (shifted16[i]),
      .rounded  (rounded16[i]),
      .carry    (carry16[i])
    );
  end

  for (genvar i = 0; i < `LANES32; i++) begin : g_lane32
    rvv_shift_lane #(.elem_t(rvv_shift_pkg::elem32_t)) i_lane (
      .shift_op (shift_op),
      .vxrm     (vxrm),
      .operand  (operand32[i]),
      .amount   (amount32[i]),
      .shifted  (shifted32[i]),
      .rounded  (rounded32[i]),
      .carry    (carry32[i])
    );
  end

  rvv_shift_result i_result (
    .clk              (clk),
    .reset            (reset),
    .uop_valid        (uop_valid),
    .legal            (legal),
    .kind             (kind),
    .shift_op         (shift_op),
    .vs2_eew          (vs2_eew),
    .uop_index        (uop_index),
    .rob_entry        (rob_entry),
    .shifted8         (shifted8),
    .rounded8         (rounded8),
    .shifted16        (shifted16),
    .rounded16        (rounded16),
    .carry16          (carry16),
    .shifted32        (shifted32),
    .rounded32        (rounded32),
    .carry32          (carry32),
    .result_valid     (result_valid),
    .result_rob_entry (result_rob_entry),
    .result_data      (result_data),
    .result_vxsat     (result_vxsat)
  );

endmodule

//--- sim/tb_rvv_alu_unit_shift.sv
`timescale 1ns/100ps
`include "rvv_shift_params.svh"

module tb_rvv_alu_unit_shift;

  localparam int reset_cycles = 5;

  typedef struct packed {
    rvv_shift_pkg::funct6_e              funct6;
    rvv_shift_pkg::funct3_e              funct3;
    rvv_shift_pkg::eew_e                 eew;
    rvv_shift_pkg::vxrm_e                vxrm;
    logic [`UOP_INDEX_WIDTH-1:0]         uop_index;
    logic [`VLEN-1:0]                    vs1;
    logic [`VLEN-1:0]                    vs2;
    logic [`XLEN-1:0]                    rs1;
    logic                                exp_valid;
    logic [`VLEN-1:0]                    exp_data;
    logic                                exp_vxsat;
  } row_t;

  logic                          clk = 1'b0;
  logic                          reset;
  logic                          uop_valid;
  rvv_shift_pkg::funct6_e        funct6;
  rvv_shift_pkg::funct3_e        funct3;
  rvv_shift_pkg::vxrm_e          vxrm;
  rvv_shift_pkg::eew_e           vs2_eew;
  logic [`UOP_INDEX_WIDTH-1:0]   uop_index;
  logic [`ROB_DEPTH_WIDTH-1:0]   rob_entry;
  logic [`VLEN-1:0]              vs1_data;
  logic [`VLEN-1:0]              vs2_data;
  logic [`XLEN-1:0]              rs1_data;
  logic                          result_valid;
  logic [`ROB_DEPTH_WIDTH-1:0]   result_rob_entry;
  logic [`VLEN-1:0]              result_data;
  logic                          result_vxsat;

  row_t rows[$];
  int   cycle_count = 0;
  int   cycle_limit;

  rvv_alu_unit_shift i_dut (
    .clk              (clk),
    .reset            (reset),
    .uop_valid        (uop_valid),
    .funct6           (funct6),
    .funct3           (funct3),
    .vxrm             (vxrm),
    .vs2_eew          (vs2_eew),
    .uop_index        (uop_index),
    .rob_entry        (rob_entry),
    .vs1_data         (vs1_data),
    .vs2_data         (vs2_data),
    .rs1_data         (rs1_data),
    .result_valid     (result_valid),
    .result_rob_entry (result_rob_entry),
    .result_data      (result_data),
    .result_vxsat     (result_vxsat)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: the run went past %0d clock cycles", cycle_limit);
      $display("sim failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, actual, expected);
      $display("sim failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic add_row(input rvv_shift_pkg::funct6_e f6, input rvv_shift_pkg::funct3_e f3,
                         input rvv_shift_pkg::eew_e eew, input rvv_shift_pkg::vxrm_e rm,
                         input logic [`UOP_INDEX_WIDTH-1:0] idx, input logic [`VLEN-1:0] vs1,
                         input logic [`VLEN-1:0] vs2, input logic [`XLEN-1:0] rs1,
                         input logic valid, input logic [`VLEN-1:0] data, input logic sat);
    row_t r;
    r = '{f6, f3, eew, rm, idx, vs1, vs2, rs1, valid, data, sat};
    rows.push_back(r);
  endtask

  // expected values worked out per element by hand
  task automatic fill_table();
    // plain shifts, per-element and scalar amounts
    add_row(rvv_shift_pkg::VSLL, rvv_shift_pkg::OPIVV, rvv_shift_pkg::EEW8, rvv_shift_pkg::RNU,
            3'd0, 64'h0907_0003_0102_0C04, 64'h8140_FF01_1234_5678, 32'h0,
            1'b1, 64'h0200_FF08_24D0_6080, 1'b0);
    add_row(rvv_shift_pkg::VSRA, rvv_shift_pkg::OPIVX, rvv_shift_pkg::EEW8, rvv_shift_pkg::RNU,
            3'd0, 64'hFFFF_FFFF_FFFF_FFFF, 64'h8140_FF01_1234_5678, 32'h0000_000B,
            1'b1, 64'hF008_FF00_0206_0A0F, 1'b0);
    add_row(rvv_shift_pkg::VSRL, rvv_shift_pkg::OPIVV, rvv_shift_pkg::EEW16, rvv_shift_pkg::RNU,
            3'd0, 64'h0011_0004_00F8_000F, 64'h8001_F0F0_1234_FFFF, 32'h0,
            1'b1, 64'h4000_0F0F_0012_0001, 1'b0);
    add_row(rvv_shift_pkg::VSRA, rvv_shift_pkg::OPIVI, rvv_shift_pkg::EEW16, rvv_shift_pkg::RNU,
            3'd0, 64'h000F_000F_000F_000F, 64'h8001_F0F0_1234_FFFF, 32'h0000_0005,
            1'b1, 64'hFC00_FF87_0091_FFFF, 1'b0);
    add_row(rvv_shift_pkg::VSLL, rvv_shift_pkg::OPIVX, rvv_shift_pkg::EEW32, rvv_shift_pkg::RNU,
            3'd0, 64'h0000_0001_0000_0001, 64'h8765_4321_0FED_CBA9, 32'h0000_0024,
            1'b1, 64'h7654_3210_FEDC_BA90, 1'b0);
    add_row(rvv_shift_pkg::VSRA, rvv_shift_pkg::OPIVV, rvv_shift_pkg::EEW32, rvv_shift_pkg::RNU,
            3'd0, 64'h0000_001F_0000_0021, 64'h8000_0000_7FFF_FFFF, 32'h0,
            1'b1, 64'hFFFF_FFFF_3FFF_FFFF, 1'b0);
    // same bytes under each rounding mode
    add_row(rvv_shift_pkg::VSSRL, rvv_shift_pkg::OPIVX, rvv_shift_pkg::EEW8, rvv_shift_pkg::RNU,
            3'd0, 64'h0707_0707_0707_0707, 64'h0904_FF08_070A_0605, 32'hFFFF_FFFA,
            1'b1, 64'h0201_4002_0203_0201, 1'b0);
    add_row(rvv_shift_pkg::VSSRL, rvv_shift_pkg::OPIVX, rvv_shift_pkg::EEW8, rvv_shift_pkg::RNE,
            3'd0, 64'h0707_0707_0707_0707, 64'h0904_FF08_070A_0605, 32'hFFFF_FFFA,
            1'b1, 64'h0201_4002_0202_0201, 1'b0);
    add_row(rvv_shift_pkg::VSSRL, rvv_shift_pkg::OPIVX, rvv_shift_pkg::EEW8, rvv_shift_pkg::RDN,
            3'd0, 64'h0707_0707_0707_0707, 64'h0904_FF08_070A_0605, 32'hFFFF_FFFA,
            1'b1, 64'h0201_3F02_0102_0101, 1'b0);
    add_row(rvv_shift_pkg::VSSRL, rvv_shift_pkg::OPIVX, rvv_shift_pkg::EEW8, rvv_shift_pkg::ROD,
            3'd0, 64'h0707_0707_0707_0707, 64'h0904_FF08_070A_0605, 32'hFFFF_FFFA,
            1'b1, 64'h0301_3F02_0103_0101, 1'b0);
    add_row(rvv_shift_pkg::VSSRA, rvv_shift_pkg::OPIVV, rvv_shift_pkg::EEW16, rvv_shift_pkg::RNU,
            3'd0, 64'h0010_0013_0002_0001, 64'hFFFF_8000_FFF6_0007, 32'h0,
            1'b1, 64'hFFFF_F000_FFFE_0004, 1'b0);
    add_row(rvv_shift_pkg::VSSRA, rvv_shift_pkg::OPIVV, rvv_shift_pkg::EEW16, rvv_shift_pkg::ROD,
            3'd0, 64'h0010_0013_0002_0001, 64'hFFFF_8000_FFF6_0007, 32'h0,
            1'b1, 64'hFFFF_F000_FFFD_0003, 1'b0);
    add_row(rvv_shift_pkg::VSSRA, rvv_shift_pkg::OPIVX, rvv_shift_pkg::EEW32, rvv_shift_pkg::RNE,
            3'd0, 64'h0, 64'hFFFF_FFF8_0000_0028, 32'h0000_0004,
            1'b1, 64'h0000_0000_0000_0002, 1'b0);
    // narrowing into the low or high half
    add_row(rvv_shift_pkg::VNSRL, rvv_shift_pkg::OPIVV, rvv_shift_pkg::EEW16, rvv_shift_pkg::RNU,
            3'd0, 64'hFFFF_FFFF_1804_0C00, 64'hABCD_1234_F00F_00FF, 32'h0,
            1'b1, 64'h0000_0000_AB23_0FFF, 1'b0);
    add_row(rvv_shift_pkg::VNSRA, rvv_shift_pkg::OPIVX, rvv_shift_pkg::EEW16, rvv_shift_pkg::RNU,
            3'd1, 64'h0F0F_0F0F_0F0F_0F0F, 64'hABCD_1234_F00F_00FF, 32'h0000_0004,
            1'b1, 64'hBC23_000F_0000_0000, 1'b0);
    add_row(rvv_shift_pkg::VNSRL, rvv_shift_pkg::OPIVV, rvv_shift_pkg::EEW32, rvv_shift_pkg::RNU,
            3'd1, 64'h0024_0010_1F1F_1F1F, 64'h8765_4321_DEAD_BEEF, 32'h0,
            1'b1, 64'h5432_DEAD_0000_0000, 1'b0);
    add_row(rvv_shift_pkg::VNSRA, rvv_shift_pkg::OPIVI, rvv_shift_pkg::EEW32, rvv_shift_pkg::RNU,
            3'd0, 64'h0, 64'h8765_4321_DEAD_BEEF, 32'h0000_0008,
            1'b1, 64'h0000_0000_6543_ADBE, 1'b0);
    // narrowing at EEW8 has no legal encoding
    add_row(rvv_shift_pkg::VNSRL, rvv_shift_pkg::OPIVV, rvv_shift_pkg::EEW8, rvv_shift_pkg::RNU,
            3'd0, 64'h0101_0101_0101_0101, 64'h1234_5678_9ABC_DEF0, 32'h0,
            1'b0, 64'h0, 1'b0);
    // clips, in range and saturating
    add_row(rvv_shift_pkg::VNCLIPU, rvv_shift_pkg::OPIVV, rvv_shift_pkg::EEW16,
            rvv_shift_pkg::RNU, 3'd0, 64'h0000_0000_0404_0100, 64'h0A08_1234_01FF_00FF, 32'h0,
            1'b1, 64'h0000_0000_A1FF_FFFF, 1'b1);
    add_row(rvv_shift_pkg::VNCLIPU, rvv_shift_pkg::OPIVX, rvv_shift_pkg::EEW32,
            rvv_shift_pkg::RDN, 3'd1, 64'h0001_0001_0001_0001, 64'hFFFF_0001_1234_5678,
            32'h0000_0010, 1'b1, 64'hFFFF_1234_0000_0000, 1'b0);
    add_row(rvv_shift_pkg::VNCLIP, rvv_shift_pkg::OPIVV, rvv_shift_pkg::EEW16, rvv_shift_pkg::RNU,
            3'd1, 64'h0102_0000_FFFF_FFFF, 64'h00FD_FF00_FF7F_0080, 32'h0,
            1'b1, 64'h7FC0_807F_0000_0000, 1'b1);
    add_row(rvv_shift_pkg::VNCLIP, rvv_shift_pkg::OPIVX, rvv_shift_pkg::EEW32, rvv_shift_pkg::RNE,
            3'd0, 64'h0101_0101_0101_0101, 64'hFFF0_0180_0012_3480, 32'h0000_0008,
            1'b1, 64'h0000_0000_F002_1234, 1'b0);
    add_row(rvv_shift_pkg::VNCLIP, rvv_shift_pkg::OPIVX, rvv_shift_pkg::EEW32, rvv_shift_pkg::ROD,
            3'd0, 64'h0101_0101_0101_0101, 64'h0000_7FFF_8000_0000, 32'h0,
            1'b1, 64'h0000_0000_7FFF_8000, 1'b1);
  endtask

  task automatic apply_row(input int k);
    uop_valid = 1'b1;
    funct6    = rows[k].funct6;
    funct3    = rows[k].funct3;
    vs2_eew   = rows[k].eew;
    vxrm      = rows[k].vxrm;
    uop_index = rows[k].uop_index;
    rob_entry = k[`ROB_DEPTH_WIDTH-1:0];
    vs1_data  = rows[k].vs1;
    vs2_data  = rows[k].vs2;
    rs1_data  = rows[k].rs1;
  endtask

  task automatic check_row(input int k);
    check_value("result_valid", 64'(result_valid), 64'(rows[k].exp_valid));
    check_value("result_data", result_data, rows[k].exp_data);
    check_value("result_vxsat", 64'(result_vxsat), 64'(rows[k].exp_vxsat));
    check_value("result_rob_entry", 64'(result_rob_entry), 64'(k[`ROB_DEPTH_WIDTH-1:0]));
  endtask

  initial begin
    fill_table();
    cycle_limit = rows.size() + reset_cycles + 20;
    reset = 1'b1;
    // a legal uop held at the inputs while in reset
    apply_row(0);
    repeat (reset_cycles) begin
      @(negedge clk);
      check_value("result_valid", 64'(result_valid), 64'd0);
      check_value("result_vxsat", 64'(result_vxsat), 64'd0);
      check_value("result_data", result_data, 64'd0);
    end
    reset     = 1'b0;
    uop_valid = 1'b0;
    @(negedge clk);
    check_value("result_valid", 64'(result_valid), 64'd0);
    apply_row(0);
    // back to back, each result one cycle later
    for (int k = 0; k < rows.size(); k++) begin
      @(negedge clk);
      check_row(k);
      if (k + 1 < rows.size()) begin
        apply_row(k + 1);
      end else begin
        uop_valid = 1'b0;
      end
    end
    @(negedge clk);
    check_value("result_valid", 64'(result_valid), 64'd0);
    $display("sim passed");
    $finish;
  end

endmodule

//--- tb.f
+incdir+include
hw/rvv_shift_pkg.sv
hw/rvv_shift_decode.sv
hw/rvv_shift_operand.sv
hw/rvv_shift_lane.sv
hw/rvv_shift_result.sv
hw/rvv_alu_unit_shift.sv
sim/tb_rvv_alu_unit_shift.sv

//--- run.sh
#!/bin/sh
# build the Verilator model, run it, then scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f tb.f --top-module tb_rvv_alu_unit_shift -Mdir obj_dir -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "sim failed" sim.log; then
  echo "result: FAIL"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulator exited with status $run_status"
  exit 1
fi
echo "result: PASS"
exit 0
